/* hw/settings_map_pkg.sv */
`default_nettype none

package settings_map_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Settings bus base addresses
   ////////////////////////////////////////////////////////////////////////////

   // Misc block offsets: +1 serdes, +2 adc, +3 led_sw, +4 phy_reset, +6 led_src
   localparam logic [7:0] SR_MISC   = 8'd0;
   // Timer offsets: +0 stage high, +1 low and load, +2 load mode
   localparam logic [7:0] SR_TIME64 = 8'd10;

   localparam logic [7:0] LED_SRC_RESET = 8'h1E;   // HW owns LEDs 1 to 4

   // Bump when the register map changes
   localparam logic [31:0] COMPAT_NUM = {16'd10, 16'd0};   // Major, minor

   ////////////////////////////////////////////////////////////////////////////
   // Readback word indices
   ////////////////////////////////////////////////////////////////////////////

   localparam logic [3:0] RB_TIME_HI = 4'd10;
   localparam logic [3:0] RB_TIME_LO = 4'd11;
   localparam logic [3:0] RB_COMPAT  = 4'd12;
   localparam logic [3:0] RB_STATUS  = 4'd13;
   localparam logic [3:0] RB_PPS_HI  = 4'd14;
   localparam logic [3:0] RB_PPS_LO  = 4'd15;

   localparam logic [31:0] RB_UNUSED = 32'hFFFF_FFFF;   // Any unmapped index

endpackage

`default_nettype wire

/* hw/ctrl_stream_pkg.sv */
`default_nettype none

package ctrl_stream_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Command and response streams
   ////////////////////////////////////////////////////////////////////////////

   // Host command, a settings write or a readback read
   typedef struct packed {
      logic        is_read;
      logic [7:0]  addr;     // Reads use bits 3:0 only
      logic [31:0] data;     // Ignored for reads
   } ctrl_cmd_t;

   // One readback word
   typedef struct packed {
      logic [3:0]  index;
      logic [31:0] data;
   } ctrl_rsp_t;

   // Internal settings bus
   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } settings_bus_t;

   ////////////////////////////////////////////////////////////////////////////
   // Buffer and credit sizes
   ////////////////////////////////////////////////////////////////////////////

   localparam int unsigned CMD_DEPTH      = 4;   // Also the host's starting credit
   localparam int unsigned RSP_DEPTH      = 4;
   localparam int unsigned RSP_CREDIT_MAX = 4;

endpackage

`default_nettype wire

/* hw/stream_fifo.sv */
`default_nettype none

module stream_fifo #(
   parameter type         payload_t = logic [31:0],
   parameter int unsigned depth     = 4
) (
   input  wire logic     dsp_clk,
   input  wire logic     por_rst,
   input  wire logic     push_i,
   input  wire payload_t din_i,
   input  wire logic     pop_i,
   output payload_t      dout_o,
   output logic          not_empty_o,
   output logic          full_o
);

   localparam int unsigned PTR_W = (depth > 1) ? $clog2(depth) : 1;
   localparam int unsigned CNT_W = $clog2(depth + 1);

   typedef logic [PTR_W-1:0] ptr_t;
   typedef logic [CNT_W-1:0] cnt_t;

   localparam ptr_t LAST = ptr_t'(depth - 1);

   payload_t mem [depth];
   ptr_t     wr_ptr;
   ptr_t     rd_ptr;
   cnt_t     count;

   always_ff @(posedge dsp_clk) begin
      if (push_i) begin
         mem[wr_ptr] <= din_i;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_i) begin
            wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;   // Wrap at depth
         end
         if (pop_i) begin
            rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
         end
         case ({push_i, pop_i})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // Idle or push and pop together
         endcase
      end
   end

   assign dout_o      = mem[rd_ptr];   // Head entry
   assign not_empty_o = (count != '0);
   assign full_o      = (count == cnt_t'(depth));

   // Producers must honour the flags they were given
   assert property (@(posedge dsp_clk) disable iff (por_rst) push_i |-> !full_o)
      else $error("stream_fifo push while full");
   assert property (@(posedge dsp_clk) disable iff (por_rst) pop_i |-> not_empty_o)
      else $error("stream_fifo pop while empty");

endmodule

`default_nettype wire

/* hw/settings_ctrl.sv */
`default_nettype none

module settings_ctrl
   import ctrl_stream_pkg::*;
   import settings_map_pkg::*;
(
   input  wire logic      dsp_clk,
   input  wire logic      por_rst,
   input  wire logic      cmd_ready_i,
   input  wire ctrl_cmd_t cmd_i,
   output logic           cmd_pop_o,
   output logic           cmd_credit_o,
   input  wire logic      rsp_full_i,
   output logic           rsp_push_o,
   output ctrl_rsp_t      rsp_o,
   input  wire logic      rsp_ready_i,
   output logic           rsp_pop_o,
   input  wire logic      rsp_credit_i,
   output logic           rsp_valid_o,
   output settings_bus_t  set_o,
   input  wire logic [63:0] vita_time_i,
   input  wire logic [63:0] vita_pps_time_i,
   input  wire logic      clk_status_i,
   input  wire logic      link_up_i,
   input  wire logic      button_i
);

   localparam int unsigned CREDIT_W = $clog2(RSP_CREDIT_MAX + 1);

   logic                stb_q;       // Write in the stage
   logic                rd_q;        // Read in the stage
   logic [7:0]          addr_q;
   logic [31:0]         data_q;
   logic                rd_ok;
   logic [31:0]         status_word;
   logic [31:0]         rb_word;
   logic [CREDIT_W-1:0] credit_q;

   ////////////////////////////////////////////////////////////////////////////
   // Command pop and registered stage
   ////////////////////////////////////////////////////////////////////////////

   // A read in the stage takes a slot unless a word leaves this cycle
   assign rd_ok     = !rsp_full_i && (!rd_q || rsp_pop_o);
   assign cmd_pop_o = cmd_ready_i && (!cmd_i.is_read || rd_ok);

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         stb_q        <= 1'b0;
         rd_q         <= 1'b0;
         cmd_credit_o <= 1'b0;
      end else begin
         stb_q        <= cmd_pop_o && !cmd_i.is_read;
         rd_q         <= cmd_pop_o && cmd_i.is_read;
         cmd_credit_o <= cmd_pop_o;   // One credit back per pop
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (cmd_pop_o) begin
         addr_q <= cmd_i.addr;
         data_q <= cmd_i.data;
      end
   end

   assign set_o = '{stb: stb_q, addr: addr_q, data: data_q};

   ////////////////////////////////////////////////////////////////////////////
   // Readback map
   ////////////////////////////////////////////////////////////////////////////

   assign status_word = {18'd0, button_i, 1'b0, clk_status_i, link_up_i, 10'd0};

   always_comb begin
      case (addr_q[3:0])
         RB_TIME_HI: rb_word = vita_time_i[63:32];
         RB_TIME_LO: rb_word = vita_time_i[31:0];
         RB_COMPAT:  rb_word = COMPAT_NUM;
         RB_STATUS:  rb_word = status_word;
         RB_PPS_HI:  rb_word = vita_pps_time_i[63:32];
         RB_PPS_LO:  rb_word = vita_pps_time_i[31:0];
         default:    rb_word = RB_UNUSED;
      endcase
   end

   assign rsp_push_o = rd_q;
   assign rsp_o      = '{index: addr_q[3:0], data: rb_word};

   ////////////////////////////////////////////////////////////////////////////
   // Response credit
   ////////////////////////////////////////////////////////////////////////////

   assign rsp_pop_o   = rsp_ready_i && (credit_q != '0);
   assign rsp_valid_o = rsp_pop_o;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         credit_q <= '0;
      end else begin
         case ({rsp_credit_i, rsp_pop_o})
            2'b10:   credit_q <= credit_q + 1'b1;
            2'b01:   credit_q <= credit_q - 1'b1;
            default: credit_q <= credit_q;   // Grant and spend cancel
         endcase
      end
   end

   // Host must not grant more than the agreed window
   assert property (@(posedge dsp_clk) disable iff (por_rst) credit_q <= RSP_CREDIT_MAX)
      else $error("settings_ctrl response credit above limit");

endmodule

`default_nettype wire

/* hw/misc_regs.sv */
`default_nettype none

module misc_regs
   import ctrl_stream_pkg::*;
   import settings_map_pkg::*;
(
   input  wire logic          dsp_clk,
   input  wire logic          por_rst,
   input  wire settings_bus_t set_i,
   input  wire logic          run_rx_i,
   input  wire logic          run_tx_i,
   input  wire logic          clk_status_i,
   input  wire logic          link_up_i,
   output logic [3:0]         ser_ctrl_o,
   output logic [3:0]         adc_ctrl_o,
   output logic               phy_resetn_o,
   output logic [7:0]         leds_o
);

   logic [3:0] serdes_q;
   logic [3:0] adc_q;
   logic [7:0] led_sw_q;
   logic       phy_reset_q;
   logic [7:0] led_src_q;   // 1 picks HW, 0 picks SW per bit
   logic [7:0] led_hw;

   ////////////////////////////////////////////////////////////////////////////
   // Settings registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         serdes_q    <= '0;
         adc_q       <= '0;
         led_sw_q    <= '0;
         phy_reset_q <= 1'b0;
         led_src_q   <= LED_SRC_RESET;
      end else if (set_i.stb) begin
         if (set_i.addr == SR_MISC + 8'd1) begin
            serdes_q <= set_i.data[3:0];   // enable, prbsen, loopen, rx_en
         end
         if (set_i.addr == SR_MISC + 8'd2) begin
            adc_q <= set_i.data[3:0];
         end
         if (set_i.addr == SR_MISC + 8'd3) begin
            led_sw_q <= set_i.data[7:0];
         end
         if (set_i.addr == SR_MISC + 8'd4) begin
            phy_reset_q <= set_i.data[0];
         end
         if (set_i.addr == SR_MISC + 8'd6) begin
            led_src_q <= set_i.data[7:0];
         end
      end
   end

   assign ser_ctrl_o   = serdes_q;
   assign adc_ctrl_o   = adc_q;
   assign phy_resetn_o = ~phy_reset_q;   // PHY reset pin is active low

   // LED mux
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, link_up_i, 1'b0};
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

endmodule

`default_nettype wire

/* hw/vita_timer.sv */
`default_nettype none

module vita_timer
   import ctrl_stream_pkg::*;
   import settings_map_pkg::*;
(
   input  wire logic          dsp_clk,
   input  wire logic          por_rst,
   input  wire settings_bus_t set_i,
   input  wire logic          pps_i,
   output logic [63:0]        vita_time_o,
   output logic [63:0]        vita_pps_time_o
);

   logic [31:0] hi_stage_q;
   logic [63:0] load_val_q;
   logic        pps_mode_q;    // Load waits for PPS when set
   logic        load_pend_q;
   logic        pps_d_q;
   logic        pps_edge;
   logic        wr_hi;
   logic        wr_lo;
   logic        wr_mode;

   assign wr_hi   = set_i.stb && (set_i.addr == SR_TIME64);
   assign wr_lo   = set_i.stb && (set_i.addr == SR_TIME64 + 8'd1);
   assign wr_mode = set_i.stb && (set_i.addr == SR_TIME64 + 8'd2);

   assign pps_edge = pps_i && !pps_d_q;   // Rising edge only

   always_ff @(posedge dsp_clk) begin
      if (wr_hi) begin
         hi_stage_q <= set_i.data;
      end
      if (wr_lo) begin
         load_val_q <= {hi_stage_q, set_i.data};
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         pps_mode_q      <= 1'b0;
         load_pend_q     <= 1'b0;
         pps_d_q         <= 1'b0;
         vita_time_o     <= '0;
         vita_pps_time_o <= '0;
      end else begin
         pps_d_q <= pps_i;
         if (wr_mode) begin
            pps_mode_q <= set_i.data[0];
         end

         // Latch sees the time before any PPS load
         if (pps_edge) begin
            vita_pps_time_o <= vita_time_o;
         end

         if (wr_lo && !pps_mode_q) begin
            vita_time_o <= {hi_stage_q, set_i.data};
         end else if (pps_edge && load_pend_q) begin
            vita_time_o <= load_val_q;
         end else begin
            vita_time_o <= vita_time_o + 64'd1;
         end

         if (wr_lo && pps_mode_q) begin
            load_pend_q <= 1'b1;   // Armed for the next edge
         end else if (pps_edge) begin
            load_pend_q <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

/* hw/radio_ctrl_top.sv */
`default_nettype none

module radio_ctrl_top
   import ctrl_stream_pkg::*;
(
   input  wire logic      dsp_clk,
   input  wire logic      por_rst,
   input  wire logic      cmd_valid_i,
   input  wire ctrl_cmd_t cmd_i,
   output logic           cmd_credit_o,
   output logic           rsp_valid_o,
   output ctrl_rsp_t      rsp_o,
   input  wire logic      rsp_credit_i,
   input  wire logic      pps_i,
   input  wire logic      run_rx_i,
   input  wire logic      run_tx_i,
   input  wire logic      clk_status_i,
   input  wire logic      link_up_i,
   input  wire logic      button_i,
   output logic [7:0]     leds_o,
   output logic [3:0]     ser_ctrl_o,
   output logic [3:0]     adc_ctrl_o,
   output logic           phy_resetn_o
);

   ctrl_cmd_t     cmd_head;
   logic          cmd_ready;
   logic          cmd_pop;
   ctrl_rsp_t     rsp_entry;
   logic          rsp_push;
   logic          rsp_pop;
   logic          rsp_ready;
   logic          rsp_full;
   settings_bus_t set_bus;
   logic [63:0]   vita_time;
   logic [63:0]   vita_pps_time;

   ////////////////////////////////////////////////////////////////////////////
   // Command and response buffers
   ////////////////////////////////////////////////////////////////////////////

   // Host credit keeps this one from filling, so full is left open
   stream_fifo #(.payload_t(ctrl_cmd_t), .depth(CMD_DEPTH)) cmd_fifo (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .push_i      (cmd_valid_i),
      .din_i       (cmd_i),
      .pop_i       (cmd_pop),
      .dout_o      (cmd_head),
      .not_empty_o (cmd_ready),
      .full_o      ()
   );

   stream_fifo #(.payload_t(ctrl_rsp_t), .depth(RSP_DEPTH)) rsp_fifo (
      .dsp_clk     (dsp_clk),
      .por_rst     (por_rst),
      .push_i      (rsp_push),
      .din_i       (rsp_entry),
      .pop_i       (rsp_pop),
      .dout_o      (rsp_o),
      .not_empty_o (rsp_ready),
      .full_o      (rsp_full)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Controller and settings targets
   ////////////////////////////////////////////////////////////////////////////

   settings_ctrl settings_ctrl_i (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .cmd_ready_i     (cmd_ready),
      .cmd_i           (cmd_head),
      .cmd_pop_o       (cmd_pop),
      .cmd_credit_o    (cmd_credit_o),
      .rsp_full_i      (rsp_full),
      .rsp_push_o      (rsp_push),
      .rsp_o           (rsp_entry),
      .rsp_ready_i     (rsp_ready),
      .rsp_pop_o       (rsp_pop),
      .rsp_credit_i    (rsp_credit_i),
      .rsp_valid_o     (rsp_valid_o),
      .set_o           (set_bus),
      .vita_time_i     (vita_time),
      .vita_pps_time_i (vita_pps_time),
      .clk_status_i    (clk_status_i),
      .link_up_i       (link_up_i),
      .button_i        (button_i)
   );

   misc_regs misc_regs_i (
      .dsp_clk      (dsp_clk),
      .por_rst      (por_rst),
      .set_i        (set_bus),
      .run_rx_i     (run_rx_i),
      .run_tx_i     (run_tx_i),
      .clk_status_i (clk_status_i),
      .link_up_i    (link_up_i),
      .ser_ctrl_o   (ser_ctrl_o),
      .adc_ctrl_o   (adc_ctrl_o),
      .phy_resetn_o (phy_resetn_o),
      .leds_o       (leds_o)
   );

   vita_timer vita_timer_i (
      .dsp_clk         (dsp_clk),
      .por_rst         (por_rst),
      .set_i           (set_bus),
      .pps_i           (pps_i),
      .vita_time_o     (vita_time),
      .vita_pps_time_o (vita_pps_time)
   );

endmodule

`default_nettype wire

/* testbench/radio_ctrl_tb.sv */
`default_nettype none

module radio_ctrl_tb
   import ctrl_stream_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int unsigned MAX_STEPS  = 64;
   localparam int          WAIT_LIMIT = 500;     // Cycles per wait loop
   localparam int          RUN_LIMIT  = 20000;   // Whole run

   // Expected readback word, exact (lo) or a window lo..hi
   typedef struct packed {
      logic        is_window;
      logic [3:0]  index;
      logic [31:0] lo;
      logic [31:0] hi;
      logic [15:0] test_id;
   } expect_t;

   logic        dsp_clk;
   logic        por_rst;
   logic        cmd_valid_i;
   ctrl_cmd_t   cmd_i;
   logic        cmd_credit_o;
   logic        rsp_valid_o;
   ctrl_rsp_t   rsp_o;
   logic        rsp_credit_i;
   logic        pps_i;
   logic        run_rx_i;
   logic        run_tx_i;
   logic        clk_status_i;
   logic        link_up_i;
   logic        button_i;
   logic [7:0]  leds_o;
   logic [3:0]  ser_ctrl_o;
   logic [3:0]  adc_ctrl_o;
   logic        phy_resetn_o;

   logic [31:0] vec_mem [4*MAX_STEPS];
   expect_t     exp_q [$];
   int          cmd_credits;    // Host side command credit
   int          credits_held;   // Granted to the DUT, not yet spent
   logic        grant_enable;
   logic        grant_next;
   int          rnd_word;
   int          seed;
   int          value_errors;
   int          timeouts;
   int          protocol_errors;

   always #5 dsp_clk = ~dsp_clk;

   radio_ctrl_top radio_ctrl_top_i (
      .dsp_clk      (dsp_clk),
      .por_rst      (por_rst),
      .cmd_valid_i  (cmd_valid_i),
      .cmd_i        (cmd_i),
      .cmd_credit_o (cmd_credit_o),
      .rsp_valid_o  (rsp_valid_o),
      .rsp_o        (rsp_o),
      .rsp_credit_i (rsp_credit_i),
      .pps_i        (pps_i),
      .run_rx_i     (run_rx_i),
      .run_tx_i     (run_tx_i),
      .clk_status_i (clk_status_i),
      .link_up_i    (link_up_i),
      .button_i     (button_i),
      .leds_o       (leds_o),
      .ser_ctrl_o   (ser_ctrl_o),
      .adc_ctrl_o   (adc_ctrl_o),
      .phy_resetn_o (phy_resetn_o)
   );

   function automatic string test_name(input logic [15:0] id);
      case (id)
         16'd1:   return "reset_state";
         16'd2:   return "misc_regs";
         16'd3:   return "status_readback";
         16'd4:   return "immediate_load";
         16'd5:   return "pps_load";
         16'd6:   return "credit_backpressure";
         default: return "unnamed";
      endcase
   endfunction

   task automatic finish_run();
      $display("Errors: %0d value, %0d timeout, %0d protocol",
               value_errors, timeouts, protocol_errors);
      if (value_errors + timeouts + protocol_errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Response checker and credit grants
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_response(input ctrl_rsp_t rsp);
      expect_t e;
      if (exp_q.size() == 0) begin
         protocol_errors++;
         $display("Response for index %0d arrived with no read outstanding", rsp.index);
      end else begin
         e = exp_q.pop_front();
         if (rsp.index != e.index) begin
            value_errors++;
            $display("ERROR %s: index expected %0d actual %0d",
                     test_name(e.test_id), e.index, rsp.index);
         end
         if (!e.is_window && rsp.data != e.lo) begin
            value_errors++;
            $display("ERROR %s: word expected %h actual %h",
                     test_name(e.test_id), e.lo, rsp.data);
         end
         if (e.is_window && (rsp.data < e.lo || rsp.data > e.hi)) begin
            value_errors++;
            $display("ERROR %s: word expected %h..%h actual %h",
                     test_name(e.test_id), e.lo, e.hi, rsp.data);
         end
      end
   endtask

   // Sample at the edge, drive 1 ns later
   always begin
      @(posedge dsp_clk);
      grant_next = 1'b0;
      rnd_word   = $random(seed);
      if (!por_rst) begin
         if (cmd_credit_o) begin
            cmd_credits++;
            if (cmd_credits > CMD_DEPTH) begin
               protocol_errors++;
               $display("Command credit returned beyond the FIFO depth");
            end
         end
         if (rsp_valid_o) begin
            check_response(rsp_o);
            credits_held--;
         end
         // Never bank more credit than reads still pending
         grant_next = grant_enable && rnd_word[0] && (credits_held < RSP_CREDIT_MAX)
                      && (credits_held < exp_q.size());
      end
      #1;
      rsp_credit_i = grant_next;
      if (grant_next) begin
         credits_held++;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Driver helpers
   ////////////////////////////////////////////////////////////////////////////

   task automatic next_cycle();
      @(posedge dsp_clk);
      #1;
   endtask

   task automatic send_cmd(input logic is_read, input logic [7:0] addr,
                           input logic [31:0] data);
      int waited;
      waited = 0;
      while (cmd_credits == 0 && waited < WAIT_LIMIT) begin
         next_cycle();
         waited++;
      end
      if (cmd_credits == 0) begin
         timeouts++;
         $display("Timed out waiting for command credit");
      end else begin
         cmd_i.is_read = is_read;
         cmd_i.addr    = addr;
         cmd_i.data    = data;
         cmd_valid_i   = 1'b1;
         cmd_credits--;
         next_cycle();
         cmd_valid_i   = 1'b0;
      end
   endtask

   task automatic issue_read(input logic [15:0] id, input logic [7:0] addr,
                             input logic is_window, input logic [31:0] lo,
                             input logic [31:0] hi);
      expect_t e;
      e.is_window = is_window;
      e.index     = addr[3:0];
      e.lo        = lo;
      e.hi        = hi;
      e.test_id   = id;
      exp_q.push_back(e);
      send_cmd(1'b1, addr, 32'd0);
   endtask

   // All credits back, then two cycles for the last strobe
   task automatic drain_commands();
      int waited;
      waited = 0;
      while (cmd_credits != CMD_DEPTH && waited < WAIT_LIMIT) begin
         next_cycle();
         waited++;
      end
      if (cmd_credits != CMD_DEPTH) begin
         timeouts++;
         $display("Timed out waiting for command credits, %0d back", cmd_credits);
      end
      repeat (2) next_cycle();
   endtask

   task automatic drain_responses();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
         next_cycle();
         waited++;
      end
      if (exp_q.size() != 0) begin
         timeouts++;
         $display("Timed out with %0d responses still missing", exp_q.size());
      end
   endtask

   task automatic pulse_pps();
      drain_commands();
      pps_i = 1'b1;
      repeat (2) next_cycle();
      pps_i = 1'b0;
      repeat (2) next_cycle();
   endtask

   task automatic check_outputs(input logic [15:0] id, input logic [7:0] exp_leds,
                                input logic [7:0] exp_ctrl, input logic exp_resetn);
      drain_commands();
      if (leds_o != exp_leds) begin
         value_errors++;
         $display("ERROR %s: leds_o expected %h actual %h", test_name(id), exp_leds, leds_o);
      end
      if ({ser_ctrl_o, adc_ctrl_o} != exp_ctrl) begin
         value_errors++;
         $display("ERROR %s: ser/adc expected %h actual %h",
                  test_name(id), exp_ctrl, {ser_ctrl_o, adc_ctrl_o});
      end
      if (phy_resetn_o != exp_resetn) begin
         value_errors++;
         $display("ERROR %s: phy_resetn_o expected %b actual %b",
                  test_name(id), exp_resetn, phy_resetn_o);
      end
   endtask

   task automatic check_quiet(input logic [15:0] id, input int cycles, input int exp_credits);
      int n;
      for (n = 0; n < cycles; n++) begin
         @(posedge dsp_clk);
         if (rsp_valid_o) begin
            protocol_errors++;
            $display("Response word left the DUT with no credit granted");
         end
         #1;
      end
      if (cmd_credits != exp_credits) begin
         value_errors++;
         $display("ERROR %s: command credit expected %0d actual %0d",
                  test_name(id), exp_credits, cmd_credits);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Vector sequencer
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      int          step;
      logic        done;
      logic [15:0] op;
      logic [15:0] id;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      dsp_clk         = 1'b0;
      por_rst         = 1'b1;
      cmd_valid_i     = 1'b0;
      cmd_i           = '0;
      rsp_credit_i    = 1'b0;
      pps_i           = 1'b0;
      run_rx_i        = 1'b0;
      run_tx_i        = 1'b0;
      clk_status_i    = 1'b0;
      link_up_i       = 1'b0;
      button_i        = 1'b0;
      cmd_credits     = CMD_DEPTH;
      credits_held    = 0;
      grant_enable    = 1'b1;
      seed            = 32'h15b54fb5;
      value_errors    = 0;
      timeouts        = 0;
      protocol_errors = 0;
      $readmemh("testbench/radio_ctrl_vectors.txt", vec_mem);

      repeat (10) @(posedge dsp_clk);
      #1;
      por_rst = 1'b0;
      if (cmd_credit_o !== 1'b0 || rsp_valid_o !== 1'b0) begin
         protocol_errors++;
         $display("Credit or response output not low after reset");
      end

      step = 0;
      done = 1'b0;
      while (!done && step < MAX_STEPS) begin
         id = vec_mem[4*step][31:16];
         op = vec_mem[4*step][15:0];
         a  = vec_mem[4*step+1];
         b  = vec_mem[4*step+2];
         c  = vec_mem[4*step+3];
         case (op)
            16'h1: send_cmd(1'b0, a[7:0], b);
            16'h2: issue_read(id, a[7:0], 1'b0, b, b);
            16'h3: issue_read(id, a[7:0], 1'b1, b, c);
            16'h4: pulse_pps();
            16'h5: begin
               {button_i, run_tx_i, run_rx_i, clk_status_i, link_up_i} = a[4:0];
               next_cycle();
            end
            16'h6: check_outputs(id, a[7:0], b[7:0], c[0]);
            16'h7: drain_responses();
            16'h8: begin
               if (a[0]) begin
                  grant_enable = 1'b1;
               end else begin
                  drain_responses();   // Spends any banked credit
                  grant_enable = 1'b0;
               end
            end
            16'h9: check_quiet(id, int'(a), int'(b));
            16'hF: done = 1'b1;
            default: begin
               protocol_errors++;
               $display("Unknown step %0d in the vector file", step);
               done = 1'b1;
            end
         endcase
         step++;
      end
      drain_responses();
      finish_run();
   end

   initial begin
      repeat (RUN_LIMIT) @(posedge dsp_clk);
      timeouts++;
      $display("Run limit of %0d cycles reached", RUN_LIMIT);
      finish_run();
   end

endmodule

`default_nettype wire

/* testbench/radio_ctrl_vectors.txt */
// Columns: iiiioooo (test id, op), then args a b c, all hex
// Ops: 1 write a=addr b=data, 2 read a=addr b=word, 3 read a=addr window b..c, 4 PPS pulse,
//      5 status a={button,run_tx,run_rx,clk_status,link_up}, 6 check a=leds b={ser,adc}
//      c=phy_resetn, 7 wait for reads, 8 credit grants a=on, 9 quiet a=cycles b=credit, F end
00010005 0000000B 00000000 00000000  // run_tx, clk_status, link_up
00010006 00000016 00000000 00000001
00010002 0000000C 000A0000 00000000  // compat 10.0
00010002 00000003 FFFFFFFF 00000000
00010002 00000020 FFFFFFFF 00000000  // upper address bits ignored
00020001 00000001 00000005 00000000  // serdes
00020001 00000002 0000000A 00000000  // adc
00020001 00000003 000000C3 00000000  // led_sw
00020001 00000004 00000001 00000000  // phy_reset
00020006 000000D7 0000005A 00000000
00020001 00000006 0000000F 00000000  // led_src
00020006 000000C6 0000005A 00000000
00020001 00000004 00000000 00000000
00020001 00000006 00000000 00000000
00020006 000000C3 0000005A 00000001
00020001 00000006 000000A5 00000000
00020006 00000046 0000005A 00000001
00030005 00000011 00000000 00000000  // button, link_up
00030002 0000000D 00002400 00000000
00030006 00000042 0000005A 00000001
00030005 00000006 00000000 00000000  // run_rx, clk_status
00030002 0000000D 00000800 00000000
00030006 00000046 0000005A 00000001
00040001 0000000A 00000001 00000000  // stage high word
00040001 0000000B 00000000 00000000  // low word loads now
00040002 0000000A 00000001 00000000
00040003 0000000B 00000000 000000C8
00050001 0000000C 00000001 00000000  // load on PPS
00050001 0000000A 00000002 00000000
00050001 0000000B 00000000 00000000
00050002 0000000A 00000001 00000000  // still the old time
00050004 00000000 00000000 00000000
00050002 0000000E 00000001 00000000  // latched before the load
00050003 0000000F 00000000 00000800
00050002 0000000A 00000002 00000000
00050004 00000000 00000000 00000000
00050002 0000000E 00000002 00000000
00050003 0000000F 00000000 00000800
00060008 00000000 00000000 00000000  // grants off
00060002 0000000C 000A0000 00000000
00060002 00000003 FFFFFFFF 00000000
00060002 0000000D 00000800 00000000
00060002 0000000C 000A0000 00000000
00060002 00000007 FFFFFFFF 00000000
00060002 0000000A 00000002 00000000
00060009 00000028 00000002 00000000  // two reads wait in the command FIFO
00060008 00000001 00000000 00000000
00060007 00000000 00000000 00000000
0000000F 00000000 00000000 00000000

/* radio_ctrl.f */
hw/settings_map_pkg.sv
hw/ctrl_stream_pkg.sv
hw/stream_fifo.sv
hw/settings_ctrl.sv
hw/misc_regs.sv
hw/vita_timer.sv
hw/radio_ctrl_top.sv
testbench/radio_ctrl_tb.sv

/* Bender.yml */
package:
  name: radio_ctrl

sources:
  - hw/settings_map_pkg.sv
  - hw/ctrl_stream_pkg.sv
  - hw/stream_fifo.sv
  - hw/settings_ctrl.sv
  - hw/misc_regs.sv
  - hw/vita_timer.sv
  - hw/radio_ctrl_top.sv
  - target: simulation
    files:
      - testbench/radio_ctrl_tb.sv
